//--- compile.f
+incdir+.
csa_pkg.sv
word_fifo.sv
repack_32_to_40.sv
csa_accumulator.sv
csa_stream_top.sv
tb_csa_stream.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir

verilator --binary --timing --assert -f compile.f --top-module tb_csa_stream \
	-Mdir "$build_dir" -o sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$("./$build_dir/sim" 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
	exit 0
fi
exit 1

//--- tb_csa_stream.sv
`timescale 1ns/1ps
`include "csa_config.svh"

module tb_csa_stream;
	import csa_pkg::*;

	localparam int in_w = `CSA_IN_WIDTH;
	localparam int op_w = `CSA_OP_WIDTH;
	localparam int blk_w = in_w * `CSA_WORDS_PER_GROUP;
	localparam int n_groups = 52;
	localparam int wd_cycles = n_groups * 40 + 200;
	localparam int rr_high = 0;
	localparam int rr_random = 1;
	localparam int rr_low = 2;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic in_ready;
	logic [in_w-1:0] in_data;
	logic res_valid;
	logic res_ready;
	result_t res;
	result_t hold_res;

	int seed;
	int errors = 0;
	int rr_mode;
	int word_cnt = 0;
	int groups_accepted = 0;
	int results_seen = 0;
	int low_run = 0;
	int max_low_run = 0;
	logic [blk_w-1:0] cur_blk;
	logic [total_width-1:0] exp_q[$];
	logic [total_width-1:0] exp_total;
	logic [seq_width-1:0] exp_seq;
	logic [seq_width-1:0] seq_next = '0;
	logic exp_avail = 1'b0;

	csa_stream_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res(res)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------

	// Word 0 lowest, cut into operand slices and summed.
	function automatic logic [total_width-1:0] group_total(input logic [blk_w-1:0] blk);
		logic [total_width-1:0] acc;
		acc = '0;
		for (int i = 0; i < `CSA_OPS_PER_GROUP; i++) begin
			acc = acc + total_width'(blk[i*op_w +: op_w]);
		end
		return acc;
	endfunction

	// Inputs and outputs are stable here, so this sees the coming edge's transfers.
	always @(negedge clk) begin
		if (rst_n) begin
			if (in_valid && in_ready) begin
				cur_blk[word_cnt*in_w +: in_w] = in_data;
				if (word_cnt == `CSA_WORDS_PER_GROUP - 1) begin
					exp_q.push_back(group_total(cur_blk));
					groups_accepted = groups_accepted + 1;
					word_cnt = 0;
				end else begin
					word_cnt = word_cnt + 1;
				end
			end
			if (res_valid && res_ready) begin
				exp_avail = (exp_q.size() > 0);
				if (exp_avail) begin
					exp_total = exp_q.pop_front();
				end
				exp_seq = seq_next;
				seq_next = seq_next + 1'b1;
				results_seen = results_seen + 1;
			end
			if (in_valid && !in_ready) begin
				low_run = low_run + 1;
			end else begin
				low_run = 0;
			end
			if (low_run > max_low_run) begin
				max_low_run = low_run;
			end
		end
	end

	always @(posedge clk) begin
		hold_res <= res;
	end

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------

	a_reset_res_valid: assert property (@(posedge clk) $rose(rst_n) |-> !res_valid)
	else begin
		errors++;
		$display("FAIL %0t: res_valid expected 0 seen %b", $time, $sampled(res_valid));
	end

	a_reset_in_ready: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
	else begin
		errors++;
		$display("FAIL %0t: in_ready expected 1 seen %b", $time, $sampled(in_ready));
	end

	a_result_expected: assert property (
		@(posedge clk) disable iff (!rst_n)
		res_valid && res_ready |-> exp_avail
	) else begin
		errors++;
		$display("Error at %0t: a result arrived with no group left to match it", $time);
	end

	a_res_total: assert property (
		@(posedge clk) disable iff (!rst_n)
		res_valid && res_ready && exp_avail |-> res.total == exp_total
	) else begin
		errors++;
		$display("FAIL %0t: res.total expected %h seen %h", $time, exp_total,
			$sampled(res.total));
	end

	a_res_seq: assert property (
		@(posedge clk) disable iff (!rst_n)
		res_valid && res_ready |-> res.seq == exp_seq
	) else begin
		errors++;
		$display("FAIL %0t: res.seq expected %0d seen %0d", $time, exp_seq, $sampled(res.seq));
	end

	a_res_valid_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid
	) else begin
		errors++;
		$display("FAIL %0t: res_valid expected 1 seen 0", $time);
	end

	a_res_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res == hold_res
	) else begin
		errors++;
		$display("FAIL %0t: res expected %h seen %h", $time, $sampled(hold_res),
			$sampled(res));
	end

	// Mid-group the repacker keeps collecting.
	a_in_ready_in_group: assert property (
		@(posedge clk) disable iff (!rst_n)
		word_cnt != 0 |-> in_ready
	) else begin
		errors++;
		$display("FAIL %0t: in_ready expected 1 seen 0", $time);
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------

	// Mode is read at the edge and the new level lands 2 ns later.
	initial begin
		logic [31:0] rnd;
		logic nxt;
		res_ready = 1'b0;
		forever begin
			@(posedge clk);
			rnd = $random(seed);
			case (rr_mode)
				rr_random: nxt = rnd[0];
				rr_low: nxt = 1'b0;
				default: nxt = 1'b1;
			endcase
			#2;
			res_ready = nxt;
		end
	end

	task automatic send_word(input logic [in_w-1:0] w);
		logic taken;
		in_valid = 1'b1;
		in_data = w;
		taken = 1'b0;
		while (!taken) begin
			taken = in_ready;
			@(posedge clk);
			#2;
		end
		in_valid = 1'b0;
	endtask

	task automatic send_group(input logic [blk_w-1:0] blk, input int max_gap);
		logic [31:0] rnd;
		int gap;
		for (int i = 0; i < `CSA_WORDS_PER_GROUP; i++) begin
			gap = 0;
			if (max_gap > 0) begin
				rnd = $random(seed);
				gap = int'(rnd % 32'(max_gap + 1));
			end
			repeat (gap) begin
				@(posedge clk);
				#2;
			end
			send_word(blk[i*in_w +: in_w]);
		end
	endtask

	task automatic random_block(output logic [blk_w-1:0] blk);
		for (int i = 0; i < `CSA_WORDS_PER_GROUP; i++) begin
			blk[i*in_w +: in_w] = $random(seed);
		end
	endtask

	task automatic wait_drain();
		while (results_seen != groups_accepted) begin
			@(posedge clk);
		end
		#2;
	endtask

	initial begin
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", wd_cycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [blk_w-1:0] blk;
		seed = 32'hb6c9_1aef;
		rr_mode = rr_high;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(posedge clk);
		#2;

		// Full carry chain, then nothing at all.
		send_group({`CSA_WORDS_PER_GROUP{32'hffff_ffff}}, 0);
		send_group('0, 0);
		repeat (10) begin
			random_block(blk);
			send_group(blk, 0);
		end
		wait_drain();

		rr_mode = rr_random;
		repeat (20) begin
			random_block(blk);
			send_group(blk, 0);
		end
		wait_drain();

		// Hold the output long enough to back up into the repacker.
		rr_mode = rr_low;
		max_low_run = 0;
		fork
			begin
				repeat (5) begin
					random_block(blk);
					send_group(blk, 0);
				end
			end
			begin
				repeat (100) @(posedge clk);
				#2;
				rr_mode = rr_high;
			end
		join
		wait_drain();
		a_backpressure: assert (max_low_run >= 30)
		else begin
			errors++;
			$display("Error: in_ready never stalled under output back-pressure");
		end

		repeat (15) begin
			random_block(blk);
			send_group(blk, 3);
		end
		wait_drain();
		repeat (5) @(posedge clk);

		a_all_groups: assert (groups_accepted == n_groups && results_seen == groups_accepted)
		else begin
			errors++;
			$display("Error: %0d groups sent, %0d accepted, %0d results returned",
				n_groups, groups_accepted, results_seen);
		end
		a_model_empty: assert (exp_q.size() == 0)
		else begin
			errors++;
			$display("Error: %0d expected totals were never matched", exp_q.size());
		end

		$display("Summary: %0d errors, %0d groups accepted, %0d results checked",
			errors, groups_accepted, results_seen);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- csa_stream_top.sv
`timescale 1ns/1ps
`include "csa_config.svh"

module csa_stream_top (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input logic [`CSA_IN_WIDTH-1:0] in_data,
	output logic res_valid,
	input logic res_ready,
	output csa_pkg::result_t res
);
	import csa_pkg::*;

	// Repacker to FIFO.
	logic op_valid;
	logic op_ready;
	operand_t op_data;

	// FIFO to accumulator.
	logic fifo_valid;
	logic fifo_ready;
	operand_t fifo_data;

	repack_32_to_40 u_repack (
		.clk(clk),
		.rst_n(rst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_data(in_data),
		.op_valid(op_valid),
		.op_ready(op_ready),
		.op_data(op_data)
	);

	word_fifo u_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.wr_valid(op_valid),
		.wr_ready(op_ready),
		.wr_data(op_data),
		.rd_valid(fifo_valid),
		.rd_ready(fifo_ready),
		.rd_data(fifo_data)
	);

	csa_accumulator u_acc (
		.clk(clk),
		.rst_n(rst_n),
		.op_valid(fifo_valid),
		.op_ready(fifo_ready),
		.op_data(fifo_data),
		.res_valid(res_valid),
		.res_ready(res_ready),
		.res(res)
	);

endmodule

//--- csa_accumulator.sv
`timescale 1ns/1ps
`include "csa_config.svh"

module csa_accumulator (
	input logic clk,
	input logic rst_n,
	input logic op_valid,
	output logic op_ready,
	input csa_pkg::operand_t op_data,
	output logic res_valid,
	input logic res_ready,
	output csa_pkg::result_t res
);
	import csa_pkg::*;

	localparam int ops = `CSA_OPS_PER_GROUP;
	localparam int cnt_w = $clog2(ops + 1);

	logic [total_width-1:0] sum_vec;
	logic [total_width-1:0] carry_vec;
	logic [total_width-1:0] sum_in;
	logic [total_width-1:0] carry_in;
	logic [total_width-1:0] op_ext;
	logic [total_width-1:0] sum_nxt;
	logic [total_width-1:0] carry_nxt;
	logic [cnt_w-1:0] op_cnt;
	logic [seq_width-1:0] seq_cnt;
	logic resolve;
	logic op_fire;
	logic res_fire;

	// Input stalls only while a finished result waits.
	assign op_ready = !res_valid;
	assign op_fire = op_valid && op_ready;
	assign res_fire = res_valid && res_ready;

	// Full group in the vectors, resolve this cycle.
	assign resolve = (op_cnt == cnt_w'(ops));

	// ------------------------------------------------------------------
	// 3:2 compression
	// ------------------------------------------------------------------

	// A new group starts from zero while the old one resolves.
	assign sum_in = resolve ? '0 : sum_vec;
	assign carry_in = resolve ? '0 : carry_vec;
	assign op_ext = total_width'(op_data);

	assign sum_nxt = sum_in ^ carry_in ^ op_ext;
	assign carry_nxt = ((sum_in & carry_in) | (sum_in & op_ext) | (carry_in & op_ext)) << 1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_vec <= '0;
			carry_vec <= '0;
			op_cnt <= '0;
		end else begin
			if (op_fire) begin
				sum_vec <= sum_nxt;
				carry_vec <= carry_nxt;
			end else if (resolve) begin
				sum_vec <= '0;
				carry_vec <= '0;
			end
			if (resolve) begin
				op_cnt <= op_fire ? cnt_w'(1) : '0;
			end else if (op_fire) begin
				op_cnt <= op_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Carry-propagate resolution and result hold
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (resolve) begin
			res.total <= sum_vec + carry_vec;
			res.seq <= seq_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res_valid <= 1'b0;
			seq_cnt <= '0;
		end else begin
			if (resolve) begin
				res_valid <= 1'b1;
				seq_cnt <= seq_cnt + 1'b1;
			end else if (res_fire) begin
				res_valid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------

	a_no_accept_on_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(op_ready && res_valid)
	) else $error("csa_accumulator: op_ready with result pending");

	a_cnt_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		op_cnt <= cnt_w'(ops)
	) else $error("csa_accumulator: operand count out of range");

	// Result shows up two cycles after the last operand of a group.
	a_res_latency: assert property (
		@(posedge clk) disable iff (!rst_n)
		op_fire && op_cnt == cnt_w'(ops - 1) |=> ##1 res_valid
	) else $error("csa_accumulator: result latency violated");

endmodule

//--- repack_32_to_40.sv
`timescale 1ns/1ps
`include "csa_config.svh"

module repack_32_to_40 (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	output logic in_ready,
	input logic [`CSA_IN_WIDTH-1:0] in_data,
	output logic op_valid,
	input logic op_ready,
	output csa_pkg::operand_t op_data
);
	import csa_pkg::*;

	localparam int words = `CSA_WORDS_PER_GROUP;
	localparam int ops = `CSA_OPS_PER_GROUP;
	localparam int widx_w = $clog2(words);
	localparam int oidx_w = $clog2(ops);

	group_buf_u group_buf;
	logic [widx_w-1:0] word_idx;
	logic [oidx_w-1:0] op_idx;
	logic emitting;
	logic in_fire;
	logic op_fire;
	logic last_word;
	logic last_op;

	// Collect while not emitting, emit while not collecting.
	assign in_ready = !emitting;
	assign op_valid = emitting;

	// Operand view of the same buffer.
	assign op_data = group_buf.ops[op_idx];

	assign in_fire = in_valid && in_ready;
	assign op_fire = op_valid && op_ready;
	assign last_word = (word_idx == widx_w'(words - 1));
	assign last_op = (op_idx == oidx_w'(ops - 1));

	// ------------------------------------------------------------------
	// Group buffer fill
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (in_fire) begin
			group_buf.words[word_idx] <= in_data;
		end
	end

	// ------------------------------------------------------------------
	// Phase and indices
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			emitting <= 1'b0;
			word_idx <= '0;
			op_idx <= '0;
		end else if (!emitting) begin
			if (in_fire) begin
				// Fifth word completes the group.
				if (last_word) begin
					word_idx <= '0;
					emitting <= 1'b1;
				end else begin
					word_idx <= word_idx + 1'b1;
				end
			end
		end else if (op_fire) begin
			if (last_op) begin
				op_idx <= '0;
				emitting <= 1'b0;
			end else begin
				op_idx <= op_idx + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------

	// A stalled operand stays offered and unchanged.
	a_op_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		op_valid && !op_ready |=> op_valid && $stable(op_data)
	) else $error("repack: op_data changed while stalled");

	a_word_idx_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		word_idx <= widx_w'(words - 1)
	) else $error("repack: word index out of range");

endmodule

//--- word_fifo.sv
`timescale 1ns/1ps
`include "csa_config.svh"

module word_fifo (
	input logic clk,
	input logic rst_n,
	input logic wr_valid,
	output logic wr_ready,
	input csa_pkg::operand_t wr_data,
	output logic rd_valid,
	input logic rd_ready,
	output csa_pkg::operand_t rd_data
);
	import csa_pkg::*;

	localparam int depth = `CSA_FIFO_DEPTH;
	localparam int ptr_w = $clog2(depth);
	localparam int cnt_w = $clog2(depth + 1);

	operand_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic do_wr;
	logic do_rd;

	// Pointer advance with wrap at the last entry.
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign wr_ready = (count != cnt_w'(depth));
	assign rd_valid = (count != '0);
	assign do_wr = wr_valid && wr_ready;
	assign do_rd = rd_valid && rd_ready;

	// Head entry is always on the output.
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ------------------------------------------------------------------
	// Pointers and occupancy
	// ------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_wr, do_rd})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

//--- csa_pkg.sv
`include "csa_config.svh"

package csa_pkg;

	// Four operands summed need two extra bits.
	localparam int total_width = `CSA_OP_WIDTH + $clog2(`CSA_OPS_PER_GROUP);

	// Group sequence tag, wraps at 256.
	localparam int seq_width = 8;

	typedef logic [`CSA_OP_WIDTH-1:0] operand_t;

	// ------------------------------------------------------------------
	// Group buffer
	// ------------------------------------------------------------------

	// Written as input words, read back as operands.
	// Element 0 sits in the lowest bits of both views.
	typedef union packed {
		logic [`CSA_WORDS_PER_GROUP-1:0][`CSA_IN_WIDTH-1:0] words;
		operand_t [`CSA_OPS_PER_GROUP-1:0] ops;
	} group_buf_u;

	// ------------------------------------------------------------------
	// Accumulator result
	// ------------------------------------------------------------------

	typedef struct packed {
		logic [total_width-1:0] total;
		logic [seq_width-1:0] seq;
	} result_t;

endpackage

//--- csa_config.svh
`ifndef CSA_CONFIG_SVH
`define CSA_CONFIG_SVH

// ----------------------------------------------------------------------
// Stream geometry
// ----------------------------------------------------------------------

// Width of one incoming stream word.
`define CSA_IN_WIDTH 32

// Width of one operand handed to the accumulator.
`define CSA_OP_WIDTH 40

// Five input words fill one group buffer.
`define CSA_WORDS_PER_GROUP 5

// The same buffer yields four operands.
`define CSA_OPS_PER_GROUP 4

// ----------------------------------------------------------------------
// Buffering
// ----------------------------------------------------------------------

// Operand FIFO entries between repacker and accumulator.
`define CSA_FIFO_DEPTH 8

`endif
